// File: hw/alu.sv
`timescale 1ns/1ps

module alu
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;
(
    input  lc3b_control_word ctrl,
    input  lc3b_instr        instr,
    input  logic [15:0]      sr1_data,
    input  logic [15:0]      sr2_data,
    output logic [15:0]      alu_out
);

logic [5:0]  offset6;
logic [15:0] offset6_word;
logic [15:0] offset6_byte;
logic [15:0] imm5_sext;
logic [15:0] operand_b;

assign offset6 = instr.offs.field;
assign offset6_word = {{9{offset6[5]}}, offset6, 1'b0};     // LDR and STR scale by 2
assign offset6_byte = {{10{offset6[5]}}, offset6};
assign imm5_sext = {{11{instr.oper.d_flag}}, instr.oper.d_flag, instr.oper.low};

always_comb
begin
    case (ctrl.alumux_sel)
        2'b01:   operand_b = ctrl.offset6mux_sel ? offset6_byte : offset6_word;
        2'b10:   operand_b = imm5_sext;
        2'b11:   operand_b = {12'h000, instr.oper.low};     // Shift amount
        default: operand_b = sr2_data;
    endcase

    case (ctrl.aluop)
        alu_and: alu_out = sr1_data & operand_b;
        alu_not: alu_out = ~sr1_data;
        alu_sll: alu_out = sr1_data << operand_b[3:0];
        alu_srl: alu_out = sr1_data >> operand_b[3:0];
        alu_sra: alu_out = $signed(sr1_data) >>> operand_b[3:0];
        default: alu_out = sr1_data + operand_b;           // Also every address
    endcase
end

endmodule

// File: hw/control_rom.sv
`timescale 1ns/1ps

module control_rom
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;
(
    input  lc3b_opcode       opcode,
    input  logic             imm_enable,
    input  logic             jsr_enable,
    input  logic             d_enable,
    input  logic             stb_high_enable,
    input  logic             is_nop,
    input  logic             flush,
    output lc3b_control_word ctrl
);

always_comb
begin
    // Defaults describe an instruction with no side effects
    ctrl.opcode = opcode;
    ctrl.aluop = alu_add;
    ctrl.alumux_sel = 2'b00;
    ctrl.regfilemux_sel = 2'b00;
    ctrl.pcmux_sel = 2'b00;
    ctrl.load_pc = 1'b0;
    ctrl.load_regfile = 1'b0;
    ctrl.load_cc = 1'b0;
    ctrl.brmux_sel = 1'b0;
    ctrl.destmux_sel = 1'b0;
    ctrl.offset6mux_sel = 1'b0;
    ctrl.regfile_filter_enable = 1'b0;
    ctrl.stb_filter_enable = 1'b0;
    ctrl.mem_read = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.mem_byte_enable = 2'b11;
    ctrl.imm_enable = 1'b0;
    ctrl.is_nop = 1'b0;

    if (flush || is_nop)
    begin
        ctrl = '0;                           // Bubble, only the PC may move
        ctrl.is_nop = 1'b1;
    end
    else
    begin
        case (opcode)
            op_add, op_and:
            begin
                ctrl.aluop = (opcode == op_add) ? alu_add : alu_and;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (imm_enable)
                begin
                    ctrl.alumux_sel = 2'b10;     // Sign-extended imm5
                    ctrl.imm_enable = 1'b1;
                end
            end

            op_not:
            begin
                ctrl.aluop = alu_not;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            op_shf:
            begin
                ctrl.alumux_sel = 2'b11;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (!d_enable)
                    ctrl.aluop = alu_sll;
                else
                begin
                    // Bit 5 picks arithmetic over logical right shift
                    ctrl.aluop = imm_enable ? alu_sra : alu_srl;
                    ctrl.imm_enable = 1'b1;
                end
            end

            // ***************************************************************
            // Memory instructions, address is base plus offset6
            // ***************************************************************
            op_ldr, op_ldb:
            begin
                ctrl.alumux_sel = 2'b01;
                ctrl.mem_read = 1'b1;
                ctrl.regfilemux_sel = 2'b01;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
                if (opcode == op_ldb)
                begin
                    ctrl.offset6mux_sel = 1'b1;
                    ctrl.regfile_filter_enable = 1'b1;   // Zero-extend the byte
                end
            end

            op_str:
            begin
                ctrl.alumux_sel = 2'b01;
                ctrl.mem_write = 1'b1;
            end

            op_stb:
            begin
                ctrl.alumux_sel = 2'b01;
                ctrl.offset6mux_sel = 1'b1;
                ctrl.stb_filter_enable = 1'b1;
                ctrl.mem_byte_enable = stb_high_enable ? 2'b10 : 2'b01;
                ctrl.mem_write = 1'b1;
            end

            // ***************************************************************
            // Control flow and LEA
            // ***************************************************************
            op_br:
            begin
                ctrl.brmux_sel = 1'b1;               // Taken only on an NZP match
                ctrl.load_pc = 1'b1;
            end

            op_jmp:
            begin
                ctrl.pcmux_sel = 2'b10;
                ctrl.load_pc = 1'b1;
            end

            op_jsr:
            begin
                // R7 gets the return address
                ctrl.destmux_sel = 1'b1;
                ctrl.regfilemux_sel = 2'b11;
                ctrl.load_regfile = 1'b1;
                ctrl.pcmux_sel = jsr_enable ? 2'b01 : 2'b10;   // JSR or JSRR
                ctrl.load_pc = 1'b1;
            end

            op_lea:
            begin
                ctrl.regfilemux_sel = 2'b10;
                ctrl.load_regfile = 1'b1;
                ctrl.load_cc = 1'b1;
            end

            default:
            begin
                ctrl = '0;                           // Unsupported opcode
            end
        endcase
    end
end

// No instruction both stores and writes back
always_comb
begin
    assert final (!(ctrl.mem_write && ctrl.load_regfile))
    else $error("control word sets mem_write and load_regfile together");
end

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module data_ram
    import lc3b_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  lc3b_control_word ctrl,
    input  logic [15:0]      mem_addr,
    input  logic [15:0]      sr_data,
    output logic [15:0]      load_data,
    output logic [15:0]      mem_wdata,
    output logic [1:0]       mem_byte_enable
);

localparam int addr_bits = $clog2(`LC3B_RAM_BYTES);

logic [7:0]           mem [`LC3B_RAM_BYTES];
logic [addr_bits-1:0] lo_addr;
logic [addr_bits-1:0] hi_addr;
logic [7:0]           lo_byte;
logic [7:0]           hi_byte;

// Word lanes, little-endian, address bit 0 ignored
assign lo_addr = {mem_addr[addr_bits-1:1], 1'b0};
assign hi_addr = {mem_addr[addr_bits-1:1], 1'b1};
assign lo_byte = mem[lo_addr];
assign hi_byte = mem[hi_addr];

// STB copies the low source byte to both lanes and the byte enable picks one
assign mem_wdata = ctrl.stb_filter_enable ? {2{sr_data[7:0]}} : sr_data;
assign mem_byte_enable = ctrl.mem_write ? ctrl.mem_byte_enable : 2'b00;

always_comb
begin
    if (!ctrl.mem_read)
        load_data = 16'h0000;
    else if (ctrl.regfile_filter_enable)
        load_data = {8'h00, mem_addr[0] ? hi_byte : lo_byte};    // LDB
    else
        load_data = {hi_byte, lo_byte};
end

always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        for (int i = 0; i < `LC3B_RAM_BYTES; i++)
            mem[i] <= 8'h00;
    end
    else
    begin
        if (mem_byte_enable[0])
            mem[lo_addr] <= mem_wdata[7:0];
        if (mem_byte_enable[1])
            mem[hi_addr] <= mem_wdata[15:8];
    end
end

word_store_full: assert property (@(posedge clk) disable iff (!rst_n)
    (ctrl.mem_write && !ctrl.stb_filter_enable) |-> ctrl.mem_byte_enable == 2'b11)
    else $error("word store without both byte lanes enabled");

endmodule

// File: hw/lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// ***************************************************************************
// Execute core configuration
// ***************************************************************************

// PC value after reset
`define LC3B_RESET_PC 16'h0000

// Data RAM size in bytes, the byte address wraps at this size
`define LC3B_RAM_BYTES 256

// Architectural register count
`define LC3B_NUM_REGS 8

`endif

// File: hw/lc3b_ctrl_pkg.sv
package lc3b_ctrl_pkg;

    import lc3b_isa_pkg::*;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    // Everything the datapath needs to finish one instruction in one cycle
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic [1:0] alumux_sel;
        logic [1:0] regfilemux_sel;
        logic [1:0] pcmux_sel;
        logic       load_pc;
        logic       load_regfile;
        logic       load_cc;
        logic       brmux_sel;
        logic       destmux_sel;       // Write R7 instead of DR
        logic       offset6mux_sel;    // Byte offset, no shift
        logic       regfile_filter_enable;
        logic       stb_filter_enable;
        logic       mem_read;
        logic       mem_write;
        logic [1:0] mem_byte_enable;
        logic       imm_enable;
        logic       is_nop;
    } lc3b_control_word;

endpackage

// File: hw/lc3b_exec_core.sv
`timescale 1ns/1ps

module lc3b_exec_core
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instr_valid,
    input  lc3b_instr   instr,
    input  logic        flush,
    output logic [15:0] pc,
    output logic [2:0]  cc,
    output logic        wb_valid,
    output logic [2:0]  wb_dest,
    output logic [15:0] wb_data,
    output logic        mem_write,
    output logic [15:0] mem_addr,
    output logic [15:0] mem_wdata,
    output logic [1:0]  mem_byte_enable
);

lc3b_control_word ctrl;
logic [15:0]      alu_out;
logic [15:0]      sr1_data;
logic [15:0]      sr2_data;
logic [15:0]      sr_data;
logic [15:0]      base_data;
logic [15:0]      load_data;
logic [15:0]      pc_next_seq;
logic [15:0]      lea_target;

assign mem_write = ctrl.mem_write;
assign mem_addr  = alu_out;                  // The ALU forms every data address

// ***************************************************************************
// Decode
// ***************************************************************************
control_rom u_control_rom (
    .opcode          (instr.oper.opcode),
    .imm_enable      (instr.oper.imm_flag),
    .jsr_enable      (instr.offs.nzp_dr[2]),  // Bit 11
    .d_enable        (instr.oper.d_flag),
    .stb_high_enable (alu_out[0]),
    .is_nop          (!instr_valid),
    .flush           (flush),
    .ctrl            (ctrl)
);

// ***************************************************************************
// Datapath
// ***************************************************************************
alu u_alu (
    .ctrl     (ctrl),
    .instr    (instr),
    .sr1_data (sr1_data),
    .sr2_data (sr2_data),
    .alu_out  (alu_out)
);

regfile u_regfile (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .instr       (instr),
    .alu_out     (alu_out),
    .load_data   (load_data),
    .pc_next_seq (pc_next_seq),
    .lea_target  (lea_target),
    .sr1_data    (sr1_data),
    .sr2_data    (sr2_data),
    .sr_data     (sr_data),
    .base_data   (base_data),
    .wb_valid    (wb_valid),
    .wb_dest     (wb_dest),
    .wb_data     (wb_data)
);

data_ram u_data_ram (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl            (ctrl),
    .mem_addr        (alu_out),
    .sr_data         (sr_data),
    .load_data       (load_data),
    .mem_wdata       (mem_wdata),
    .mem_byte_enable (mem_byte_enable)
);

pc_unit u_pc_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl        (ctrl),
    .instr       (instr),
    .instr_valid (instr_valid),
    .base_data   (base_data),
    .wb_data     (wb_data),
    .pc          (pc),
    .cc          (cc),
    .pc_next_seq (pc_next_seq),
    .lea_target  (lea_target)
);

endmodule

// File: hw/lc3b_isa_pkg.sv
package lc3b_isa_pkg;

    // LC-3b opcode encodings, including those the core does not execute
    typedef enum logic [3:0] {
        op_br   = 4'h0,
        op_add  = 4'h1,
        op_ldb  = 4'h2,
        op_stb  = 4'h3,
        op_jsr  = 4'h4,
        op_and  = 4'h5,
        op_ldr  = 4'h6,
        op_str  = 4'h7,
        op_rti  = 4'h8,
        op_not  = 4'h9,
        op_ldi  = 4'ha,
        op_sti  = 4'hb,
        op_jmp  = 4'hc,
        op_shf  = 4'hd,
        op_lea  = 4'he,
        op_trap = 4'hf
    } lc3b_opcode;

    // Operate format: ADD, AND, NOT, SHF
    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] dr;
        logic [2:0] sr1;
        logic       imm_flag;    // Bit 5, immediate or arithmetic shift
        logic       d_flag;      // Bit 4, shift direction
        logic [3:0] low;         // SR2, imm5 low part or shift amount
    } lc3b_operate_view;

    // Offset format: memory, branch, jump and LEA
    typedef struct packed {
        lc3b_opcode opcode;
        logic [2:0] nzp_dr;      // NZP for BR, DR or SR otherwise
        logic [2:0] base;
        logic [5:0] field;       // Offset6, low part of offset9 and offset11
    } lc3b_offset_view;

    typedef union packed {
        lc3b_operate_view oper;
        lc3b_offset_view  offs;
    } lc3b_instr;

endpackage

// File: hw/pc_unit.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module pc_unit
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  lc3b_control_word ctrl,
    input  lc3b_instr        instr,
    input  logic             instr_valid,
    input  logic [15:0]      base_data,
    input  logic [15:0]      wb_data,
    output logic [15:0]      pc,
    output logic [2:0]       cc,
    output logic [15:0]      pc_next_seq,
    output logic [15:0]      lea_target
);

logic [15:0] offset9_shifted;
logic [15:0] offset11_shifted;
logic [15:0] pc_target;
logic [2:0]  cc_next;
logic        br_taken;

assign offset9_shifted = {{6{instr.offs.base[2]}}, instr.offs.base,
                          instr.offs.field, 1'b0};
assign offset11_shifted = {{4{instr.offs.nzp_dr[1]}}, instr.offs.nzp_dr[1:0],
                           instr.offs.base, instr.offs.field, 1'b0};

assign pc_next_seq = pc + 16'd2;
assign lea_target = pc_next_seq + offset9_shifted;    // Shared by BR and LEA

assign br_taken = ctrl.brmux_sel && |(instr.offs.nzp_dr & cc);

always_comb
begin
    case (ctrl.pcmux_sel)
        2'b01:   pc_target = pc_next_seq + offset11_shifted;    // JSR
        2'b10:   pc_target = base_data;                         // JMP and JSRR
        default: pc_target = br_taken ? lea_target : pc_next_seq;
    endcase

    // N, Z, P from the written value
    if (wb_data[15])
        cc_next = 3'b100;
    else if (wb_data == 16'h0000)
        cc_next = 3'b010;
    else
        cc_next = 3'b001;
end

always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        pc <= `LC3B_RESET_PC;
        cc <= 3'b010;
    end
    else
    begin
        if (instr_valid)                     // Flushed instructions still advance
            pc <= ctrl.load_pc ? pc_target : pc_next_seq;
        if (ctrl.load_cc)
            cc <= cc_next;
    end
end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module regfile
    import lc3b_isa_pkg::*;
    import lc3b_ctrl_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  lc3b_control_word ctrl,
    input  lc3b_instr        instr,
    input  logic [15:0]      alu_out,
    input  logic [15:0]      load_data,
    input  logic [15:0]      pc_next_seq,
    input  logic [15:0]      lea_target,
    output logic [15:0]      sr1_data,
    output logic [15:0]      sr2_data,
    output logic [15:0]      sr_data,
    output logic [15:0]      base_data,
    output logic             wb_valid,
    output logic [2:0]       wb_dest,
    output logic [15:0]      wb_data
);

logic [15:0] regs [`LC3B_NUM_REGS];

// Reads see the old contents, so JSRR through R7 jumps to the old R7
assign sr1_data  = regs[instr.oper.sr1];
assign sr2_data  = regs[instr.oper.low[2:0]];
assign sr_data   = regs[instr.offs.nzp_dr];    // Store source sits in the DR field
assign base_data = regs[instr.offs.base];

assign wb_valid = ctrl.load_regfile;
assign wb_dest  = ctrl.destmux_sel ? 3'd7 : instr.oper.dr;

always_comb
begin
    case (ctrl.regfilemux_sel)
        2'b01:   wb_data = load_data;
        2'b10:   wb_data = lea_target;
        2'b11:   wb_data = pc_next_seq;        // Return address for JSR
        default: wb_data = alu_out;
    endcase
end

always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        for (int i = 0; i < `LC3B_NUM_REGS; i++)
            regs[i] <= 16'h0000;
    end
    else if (wb_valid)
        regs[wb_dest] <= wb_data;
end

wb_data_known: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> !$isunknown(wb_data))
    else $error("write-back data is unknown");

endmodule

// File: test/clk_gen.sv
`timescale 1ns/1ps

module clk_gen
(
    output logic clk,
    output logic rst_n
);

initial
begin
    clk = 1'b0;
    forever #2 clk = ~clk;              // 4 ns period
end

// Reset is held for the first ten rising edges
initial
begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
end

endmodule

// File: test/tb_lc3b_exec_core.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module tb_lc3b_exec_core;

localparam int num_instrs    = 2000;
localparam int reset_timeout = 100;

localparam logic [3:0] op_br  = 4'h0;
localparam logic [3:0] op_add = 4'h1;
localparam logic [3:0] op_ldb = 4'h2;
localparam logic [3:0] op_stb = 4'h3;
localparam logic [3:0] op_jsr = 4'h4;
localparam logic [3:0] op_and = 4'h5;
localparam logic [3:0] op_ldr = 4'h6;
localparam logic [3:0] op_str = 4'h7;
localparam logic [3:0] op_not = 4'h9;
localparam logic [3:0] op_jmp = 4'hc;
localparam logic [3:0] op_shf = 4'hd;
localparam logic [3:0] op_lea = 4'he;

logic        clk;
logic        rst_n;
logic        instr_valid;
logic [15:0] instr;
logic        flush;
logic [15:0] pc;
logic [2:0]  cc;
logic        wb_valid;
logic [2:0]  wb_dest;
logic [15:0] wb_data;
logic        mem_write;
logic [15:0] mem_addr;
logic [15:0] mem_wdata;
logic [1:0]  mem_byte_enable;

// Architectural state of the reference model
logic [15:0] m_regs [8];
logic [7:0]  m_ram [`LC3B_RAM_BYTES];
logic [15:0] m_pc;
logic [2:0]  m_cc;

// Expected results of the instruction in flight
logic        e_wb_valid;
logic [2:0]  e_wb_dest;
logic [15:0] e_wb_data;
logic        e_load_cc;
logic        e_mem_access;
logic        e_mem_write;
logic [15:0] e_mem_addr;
logic [15:0] e_mem_wdata;
logic [1:0]  e_mem_be;
logic [15:0] e_pc_next;

logic [31:0] rng_state;
logic [15:0] last_store;
logic        have_store;

clk_gen u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
);

lc3b_exec_core DUT (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_valid     (instr_valid),
    .instr           (instr),
    .flush           (flush),
    .pc              (pc),
    .cc              (cc),
    .wb_valid        (wb_valid),
    .wb_dest         (wb_dest),
    .wb_data         (wb_data),
    .mem_write       (mem_write),
    .mem_addr        (mem_addr),
    .mem_wdata       (mem_wdata),
    .mem_byte_enable (mem_byte_enable)
);

// ***************************************************************************
// Helpers
// ***************************************************************************
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Sign-extends the low bits of v to 16 bits
function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
    logic [15:0] r;
    r = v;
    for (int i = bits; i < 16; i++)
        r[i] = v[bits-1];
    return r;
endfunction

function automatic int byte_index(input logic [15:0] a);
    return a % `LC3B_RAM_BYTES;             // RAM wraps at its size
endfunction

function automatic logic [2:0] cc_of(input logic [15:0] v);
    if (v[15])
        return 3'b100;
    else if (v == 16'h0000)
        return 3'b010;
    return 3'b001;
endfunction

function automatic logic [3:0] pick_opcode(input int sel);
    case (sel)
        0:       return op_br;
        1:       return op_add;
        2:       return op_and;
        3:       return op_not;
        4:       return op_shf;
        5:       return op_lea;
        6:       return op_jmp;
        7:       return op_jsr;
        8:       return op_ldr;
        9:       return op_ldb;
        10:      return op_str;
        default: return op_stb;
    endcase
endfunction

task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "first error reached");
endtask

task automatic check_value(input string name, input logic [15:0] expected,
                           input logic [15:0] actual);
    if (actual !== expected)
        stop_with_failure($sformatf("[FAIL] %s expected %h actual %h",
                                    name, expected, actual));
endtask

// ***************************************************************************
// Stimulus and reference model
// ***************************************************************************
task automatic make_instr(output logic [15:0] iw, output logic v, output logic fl);
    logic [31:0] r;
    int          kind;
    rng_state = xorshift32(rng_state);
    r = rng_state;
    kind = r[31:24] % 100;
    iw = r[15:0];
    v = 1'b1;
    fl = 1'b0;
    if (kind < 4)
        v = 1'b0;                           // Bubble, bits are random
    else if (kind < 8)
        fl = 1'b1;
    else if (kind < 12)
        iw[15:12] = r[17] ? (r[16] ? 4'hf : 4'hb) : (r[16] ? 4'ha : 4'h8);
    else
    begin
        iw[15:12] = pick_opcode(r[23:16] % 12);
        if (iw[15:12] == op_not)
            iw[5:0] = 6'h3f;
        if ((iw[15:12] == op_ldr || iw[15:12] == op_ldb) && r[20] && have_store)
        begin
            // Read back through the last store's base and offset
            iw[8:0] = last_store[8:0];
            iw[15:12] = (last_store[15:12] == op_str) ? op_ldr : op_ldb;
        end
        if (iw[15:12] == op_str || iw[15:12] == op_stb)
        begin
            last_store = iw;
            have_store = 1'b1;
        end
    end
endtask

task automatic model_step(input logic [15:0] iw, input logic v, input logic fl);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] addr;
    int          lo;
    e_wb_valid = 1'b0;
    e_wb_dest = iw[11:9];
    e_wb_data = 16'h0000;
    e_load_cc = 1'b0;
    e_mem_access = 1'b0;
    e_mem_write = 1'b0;
    e_mem_addr = 16'h0000;
    e_mem_wdata = 16'h0000;
    e_mem_be = 2'b00;
    e_pc_next = v ? m_pc + 16'd2 : m_pc;
    a = m_regs[iw[8:6]];
    if (v && !fl)
    begin
        case (iw[15:12])
            op_add, op_and, op_not, op_shf:
            begin
                b = iw[5] ? sext(iw, 5) : m_regs[iw[2:0]];
                case (iw[15:12])
                    op_add:  e_wb_data = a + b;
                    op_and:  e_wb_data = a & b;
                    op_not:  e_wb_data = ~a;
                    default:
                        if (!iw[4])
                            e_wb_data = a << iw[3:0];
                        else if (iw[5])
                            e_wb_data = $signed(a) >>> iw[3:0];
                        else
                            e_wb_data = a >> iw[3:0];
                endcase
                e_wb_valid = 1'b1;
                e_load_cc = 1'b1;
            end
            op_ldr, op_ldb:
            begin
                e_mem_access = 1'b1;
                e_wb_valid = 1'b1;
                e_load_cc = 1'b1;
                if (iw[15:12] == op_ldr)
                begin
                    addr = a + (sext(iw, 6) << 1);
                    lo = byte_index({addr[15:1], 1'b0});
                    e_wb_data = {m_ram[lo + 1], m_ram[lo]};
                end
                else
                begin
                    addr = a + sext(iw, 6);
                    e_wb_data = {8'h00, m_ram[byte_index(addr)]};
                end
                e_mem_addr = addr;
            end
            op_str, op_stb:
            begin
                e_mem_access = 1'b1;
                e_mem_write = 1'b1;
                if (iw[15:12] == op_str)
                begin
                    e_mem_addr = a + (sext(iw, 6) << 1);
                    e_mem_wdata = m_regs[iw[11:9]];
                    e_mem_be = 2'b11;
                end
                else
                begin
                    e_mem_addr = a + sext(iw, 6);
                    e_mem_be = e_mem_addr[0] ? 2'b10 : 2'b01;
                    if (e_mem_addr[0])
                        e_mem_wdata = {m_regs[iw[11:9]][7:0], 8'h00};
                    else
                        e_mem_wdata = {8'h00, m_regs[iw[11:9]][7:0]};
                end
            end
            op_br:
                if (|(iw[11:9] & m_cc))
                    e_pc_next = m_pc + 16'd2 + (sext(iw, 9) << 1);
            op_jmp:
                e_pc_next = a;
            op_jsr:
            begin
                e_wb_valid = 1'b1;
                e_wb_dest = 3'd7;
                e_wb_data = m_pc + 16'd2;
                e_pc_next = iw[11] ? m_pc + 16'd2 + (sext(iw, 11) << 1) : a;
            end
            op_lea:
            begin
                e_wb_valid = 1'b1;
                e_wb_data = m_pc + 16'd2 + (sext(iw, 9) << 1);
                e_load_cc = 1'b1;
            end
            default:
                e_pc_next = m_pc + 16'd2;   // Dropped opcodes only advance
        endcase
    end
endtask

task automatic model_commit;
    int lo;
    lo = byte_index({e_mem_addr[15:1], 1'b0});
    if (e_wb_valid)
        m_regs[e_wb_dest] = e_wb_data;
    if (e_load_cc)
        m_cc = cc_of(e_wb_data);
    if (e_mem_be[0])
        m_ram[lo] = e_mem_wdata[7:0];
    if (e_mem_be[1])
        m_ram[lo + 1] = e_mem_wdata[15:8];
    m_pc = e_pc_next;
endtask

// ***************************************************************************
// Test sequence
// ***************************************************************************
initial
begin
    int          waited;
    logic [15:0] iw;
    logic        v;
    logic        fl;
    string       tag;
    instr_valid = 1'b0;
    instr = 16'h0000;
    flush = 1'b0;
    rng_state = 32'd11892;
    last_store = 16'h0000;
    have_store = 1'b0;
    for (int i = 0; i < 8; i++)
        m_regs[i] = 16'h0000;
    for (int i = 0; i < `LC3B_RAM_BYTES; i++)
        m_ram[i] = 8'h00;
    m_pc = `LC3B_RESET_PC;
    m_cc = 3'b010;

    waited = 0;
    while (rst_n !== 1'b1)
    begin
        @(posedge clk);
        waited++;
        if (waited > reset_timeout)
            stop_with_failure("reset was never released");
    end
    @(negedge clk);
    check_value("reset pc", `LC3B_RESET_PC, pc);
    check_value("reset cc", 3'b010, cc);
    check_value("reset wb_valid", 1'b0, wb_valid);
    check_value("reset mem_write", 1'b0, mem_write);

    for (int i = 0; i < num_instrs; i++)
    begin
        make_instr(iw, v, fl);
        @(posedge clk);
        instr <= iw;
        instr_valid <= v;
        flush <= fl;
        @(negedge clk);
        tag = $sformatf("instr %0d word %h valid %b flush %b", i, iw, v, fl);
        check_value({tag, " pc"}, m_pc, pc);    // State left by earlier instructions
        check_value({tag, " cc"}, m_cc, cc);
        model_step(iw, v, fl);
        check_value({tag, " wb_valid"}, e_wb_valid, wb_valid);
        if (e_wb_valid)
        begin
            check_value({tag, " wb_dest"}, e_wb_dest, wb_dest);
            check_value({tag, " wb_data"}, e_wb_data, wb_data);
        end
        check_value({tag, " mem_write"}, e_mem_write, mem_write);
        check_value({tag, " mem_byte_enable"}, e_mem_be, mem_byte_enable);
        if (e_mem_access)
            check_value({tag, " mem_addr"}, e_mem_addr, mem_addr);
        if (e_mem_write)
            check_value({tag, " mem_wdata"}, e_mem_wdata,
                        mem_wdata & {{8{e_mem_be[1]}}, {8{e_mem_be[0]}}});
        model_commit();
    end

    // One idle cycle exposes the last instruction's pc and cc
    @(posedge clk);
    instr_valid <= 1'b0;
    flush <= 1'b0;
    @(negedge clk);
    check_value("final pc", m_pc, pc);
    check_value("final cc", m_cc, cc);
    $display("SIMULATION PASSED");
    $finish;
end

endmodule

// File: verilog.f
+incdir+hw
hw/lc3b_isa_pkg.sv
hw/lc3b_ctrl_pkg.sv
hw/control_rom.sv
hw/alu.sv
hw/regfile.sv
hw/data_ram.sv
hw/pc_unit.sv
hw/lc3b_exec_core.sv
test/clk_gen.sv
test/tb_lc3b_exec_core.sv
